//--- files.f
+incdir+.
eth_mgmt_pkg.sv
reset_sync.sv
mdio_master.sv
phy_init_seq.sv
board_mgmt_top.sv
tb_board_mgmt_top.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f files.f --top-module tb_board_mgmt_top -o tb_sim
	./obj_dir/tb_sim | tee sim.log
	grep -q "=== PASS ===" sim.log

clean:
	rm -rf obj_dir sim.log

//--- tb_board_mgmt_top.sv
//--------------------
// directed testbench for the board management top level
// decodes the MDIO write frames, checks startup latency, done flag,
// LED select and restart after a reset during a frame
//--------------------
`timescale 1ns/1ps

module tb_board_mgmt_top;

    localparam int INIT_DELAY   = 40;
    localparam int MDC_PRESCALE = 3;
    localparam int SYNC_STAGES  = 4;
    localparam int FRAME_CYCLES = 128 * (MDC_PRESCALE + 1);
    localparam int CYCLE_LIMIT  = 2 * (SYNC_STAGES + INIT_DELAY + 13 * 512);

    logic        clk_125mhz_int;
    logic        gt_tx_reset;
    logic        sel_i;
    logic [7:0]  lane_lock_i;
    logic [7:0]  core_led_i;
    logic [7:0]  led_o;
    logic        mdc_o;
    logic        mdio_o;
    logic        mdio_t_o;
    logic        init_done_o;
    logic [31:0] lfsr_state;
    int          cycles = 0;

    board_mgmt_top #(
        .INIT_DELAY  (20'(INIT_DELAY)),
        .MDC_PRESCALE(8'(MDC_PRESCALE))
    ) u_dut (
        .clk_125mhz_int(clk_125mhz_int),
        .gt_tx_reset   (gt_tx_reset),
        .sel_i         (sel_i),
        .lane_lock_i   (lane_lock_i),
        .core_led_i    (core_led_i),
        .led_o         (led_o),
        .mdc_o         (mdc_o),
        .mdio_o        (mdio_o),
        .mdio_t_o      (mdio_t_o),
        .init_done_o   (init_done_o)
    );

    initial begin
        clk_125mhz_int = 1'b0;
        forever #4 clk_125mhz_int = ~clk_125mhz_int;
    end

    always @(posedge clk_125mhz_int) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("=== FAIL ===");
            $fatal(1, "timeout: tests still running after %0d cycles", CYCLE_LIMIT);
        end
    end

    // galois lfsr, one step per bit
    function automatic logic next_bit();
        logic lsb;
        lsb = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (lsb) begin
            lfsr_state = lfsr_state ^ 32'hA300_0000;
        end
        return lsb;
    endfunction

    function automatic logic [7:0] random_byte();
        logic [7:0] value;
        for (int i = 0; i < 8; i++) begin
            value[i] = next_bit();
        end
        return value;
    endfunction

    // write frame for one step of the REGCR/ADDAR table
    function automatic logic [63:0] expected_frame(int step);
        logic [4:0]  regad;
        logic [15:0] data;
        regad = (step % 2 == 1) ? 5'h0E : 5'h0D;
        case (step)
            0, 4, 8:  data = 16'h001F;
            2, 6, 10: data = 16'h401F;
            1:        data = 16'h0031;
            3:        data = 16'h0070;
            5:        data = 16'h00D3;
            7:        data = 16'h4000;
            9:        data = 16'h016F;
            default:  data = 16'h0015;
        endcase
        return {32'hFFFF_FFFF, 2'b01, 2'b01, 5'd3, regad, 2'b10, data};
    endfunction

    task automatic check(input string what, input logic [63:0] actual,
                         input logic [63:0] expected);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("=== FAIL ===");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // called on a falling edge
    task automatic pulse_reset();
        gt_tx_reset = 1'b1;
        repeat (3) @(negedge clk_125mhz_int);
        gt_tx_reset = 1'b0;
    endtask

    // called on a falling edge while a frame is on the bus
    task automatic reset_mid_frame();
        gt_tx_reset = 1'b1;
        #1;
        check("mdio_t_o right after reset", 64'(mdio_t_o), 64'd1);
        repeat (3) @(negedge clk_125mhz_int);
        gt_tx_reset = 1'b0;
    endtask

    // counts from the release edge to the first driven bit
    task automatic check_start_latency();
        int n;
        n = 0;
        while (mdio_t_o !== 1'b0) begin
            @(negedge clk_125mhz_int);
            n++;
        end
        check("cycles to first frame", 64'(n), 64'(SYNC_STAGES + INIT_DELAY + 2));
    endtask

    // bits are taken at each mdc rise while the pin is driven
    task automatic decode_frame(output logic [63:0] frame);
        int   nbits;
        int   low_cycles;
        logic mdc_prev;
        nbits = 0;
        frame = '0;
        while (mdio_t_o !== 1'b0) @(negedge clk_125mhz_int);
        low_cycles = 1;
        mdc_prev = mdc_o;
        while (mdio_t_o === 1'b0) begin
            @(negedge clk_125mhz_int);
            if (mdio_t_o === 1'b0) begin
                low_cycles++;
                if (mdc_o && !mdc_prev) begin
                    frame = {frame[62:0], mdio_o};
                    nbits++;
                end
                mdc_prev = mdc_o;
            end
        end
        check("bits in frame", 64'(nbits), 64'd64);
        check("cycles in frame", 64'(low_cycles), 64'(FRAME_CYCLES));
    endtask

    task automatic check_reset_state();
        check("mdio_t_o in reset", 64'(mdio_t_o), 64'd1);
        check("mdio_o in reset", 64'(mdio_o), 64'd1);
        check("mdc_o in reset", 64'(mdc_o), 64'd0);
        check("init_done_o in reset", 64'(init_done_o), 64'd0);
    endtask

    // done stays low until the last frame has left the bus
    task automatic check_init_frames();
        logic [63:0] frame;
        for (int s = 0; s < 12; s++) begin
            decode_frame(frame);
            check($sformatf("frame %0d", s), frame, expected_frame(s));
            check("init_done_o during sequence", 64'(init_done_o), 64'd0);
        end
    endtask

    // bus stays released once the sequence is done
    task automatic check_done_quiet();
        while (init_done_o !== 1'b1) @(negedge clk_125mhz_int);
        repeat (1000) begin
            @(negedge clk_125mhz_int);
            check("mdio_t_o after done", 64'(mdio_t_o), 64'd1);
            check("init_done_o after done", 64'(init_done_o), 64'd1);
        end
    endtask

    task automatic check_led_select();
        for (int i = 0; i < 32; i++) begin
            @(negedge clk_125mhz_int);
            sel_i = next_bit();
            lane_lock_i = random_byte();
            core_led_i = random_byte();
            @(posedge clk_125mhz_int);
            if (sel_i) begin
                check("led_o with sel_i high", 64'(led_o), 64'(lane_lock_i));
            end else begin
                check("led_o with sel_i low", 64'(led_o), 64'(core_led_i));
            end
        end
    endtask

    task automatic reset_during_frame();
        logic [63:0] frame;
        @(negedge clk_125mhz_int);
        pulse_reset();
        check_start_latency();
        for (int s = 0; s < 4; s++) begin
            decode_frame(frame);
            check($sformatf("frame %0d before reset", s), frame, expected_frame(s));
        end
        while (mdio_t_o !== 1'b0) @(negedge clk_125mhz_int);
        repeat (100) @(negedge clk_125mhz_int);
        reset_mid_frame();
        check_start_latency();
        decode_frame(frame);
        check("first frame after restart", frame, expected_frame(0));
    endtask

    initial begin
        gt_tx_reset = 1'b1;
        sel_i = 1'b0;
        lane_lock_i = 8'd0;
        core_led_i = 8'd0;
        lfsr_state = 32'h01e12a3d;
        repeat (3) @(negedge clk_125mhz_int);
        check_reset_state();
        gt_tx_reset = 1'b0;
        check_start_latency();
        check_init_frames();
        check_done_quiet();
        check_led_select();
        reset_during_frame();
        $display("=== PASS ===");
        $finish;
    end

endmodule

//--- board_mgmt_top.sv
//--------------------
// board management top level
// reset synchronizer, PHY init sequencer and MDIO write engine
// on clk_125mhz_int, plus the LED source select
//--------------------
`timescale 1ns/1ps
`include "eth_mgmt_macros.svh"

module board_mgmt_top #(
    parameter logic [19:0] INIT_DELAY   = `ETH_MGMT_INIT_DELAY,
    parameter logic [7:0]  MDC_PRESCALE = `ETH_MGMT_MDC_PRESCALE
) (
    input  logic                       clk_125mhz_int,
    input  logic                       gt_tx_reset,
    input  logic                       sel_i,
    input  logic [`ETH_MGMT_LANES-1:0] lane_lock_i,
    input  logic [7:0]                 core_led_i,
    output logic [7:0]                 led_o,
    output logic                       mdc_o,
    output logic                       mdio_o,
    output logic                       mdio_t_o,
    output logic                       init_done_o
);

    logic                     rst_local;
    eth_mgmt_pkg::phy_reg_t   cmd_reg;
    eth_mgmt_pkg::mdio_data_t cmd_data;
    logic                     cmd_valid;
    logic                     cmd_ready;

    reset_sync #(
        .STAGES(`ETH_MGMT_SYNC_STAGES)
    ) u_reset_sync (
        .clk_125mhz_int(clk_125mhz_int),
        .gt_tx_reset   (gt_tx_reset),
        .rst_o         (rst_local)
    );

    phy_init_seq #(
        .INIT_DELAY(INIT_DELAY)
    ) u_phy_init_seq (
        .clk_125mhz_int(clk_125mhz_int),
        .rst_i         (rst_local),
        .cmd_ready_i   (cmd_ready),
        .cmd_reg_o     (cmd_reg),
        .cmd_data_o    (cmd_data),
        .cmd_valid_o   (cmd_valid),
        .init_done_o   (init_done_o)
    );

    mdio_master #(
        .PRESCALE(MDC_PRESCALE)
    ) u_mdio_master (
        .clk_125mhz_int(clk_125mhz_int),
        .rst_i         (rst_local),
        .cmd_reg_i     (cmd_reg),
        .cmd_data_i    (cmd_data),
        .cmd_valid_i   (cmd_valid),
        .cmd_ready_o   (cmd_ready),
        .mdc_o         (mdc_o),
        .mdio_o        (mdio_o),
        .mdio_t_o      (mdio_t_o)
    );

    // switch picks block-lock flags or the core LED byte
    assign led_o = sel_i ? lane_lock_i : core_led_i;

endmodule

//--- phy_init_seq.sv
//--------------------
// SGMII PHY init sequencer
// waits INIT_DELAY cycles after reset, then issues twelve MDIO
// writes through REGCR/ADDAR and raises init_done_o when the
// last frame is out
//--------------------
`timescale 1ns/1ps
`include "eth_mgmt_macros.svh"

module phy_init_seq #(
    parameter logic [19:0] INIT_DELAY = `ETH_MGMT_INIT_DELAY
) (
    input  logic                     clk_125mhz_int,
    input  logic                     rst_i,
    input  logic                     cmd_ready_i,
    output eth_mgmt_pkg::phy_reg_t   cmd_reg_o,
    output eth_mgmt_pkg::mdio_data_t cmd_data_o,
    output logic                     cmd_valid_o,
    output logic                     init_done_o
);

    eth_mgmt_pkg::seq_state_e state;
    logic [19:0] delay_cnt;
    logic [3:0]  step;
    logic        accept;

    assign accept      = cmd_valid_o && cmd_ready_i;
    assign init_done_o = (state == eth_mgmt_pkg::SEQ_DONE);

    // command table, even steps program REGCR, odd steps ADDAR
    always_comb begin
        cmd_reg_o = step[0] ? `ETH_MGMT_REG_ADDAR : `ETH_MGMT_REG_REGCR;
        case (step)
            // CFG4 address, then autoneg timer value
            4'd1:    cmd_data_o = 16'h0031;
            4'd3:    cmd_data_o = 16'h0070;
            // SGMIICTL1 address, then clock output enable
            4'd5:    cmd_data_o = 16'h00D3;
            4'd7:    cmd_data_o = 16'h4000;
            // 10M_SGMII_CFG address, then 10 Mbps enable
            4'd9:    cmd_data_o = 16'h016F;
            4'd11:   cmd_data_o = 16'h0015;
            default: cmd_data_o = step[1] ? `ETH_MGMT_REGCR_DATA : `ETH_MGMT_REGCR_ADDR;
        endcase
    end

    always_ff @(posedge clk_125mhz_int or posedge rst_i) begin
        if (rst_i) begin
            state       <= eth_mgmt_pkg::SEQ_DELAY;
            delay_cnt   <= INIT_DELAY;
            step        <= 4'd0;
            cmd_valid_o <= 1'b0;
        end else begin
            case (state)
                eth_mgmt_pkg::SEQ_DELAY: begin
                    if (delay_cnt == 20'd0) begin
                        state       <= eth_mgmt_pkg::SEQ_ISSUE;
                        cmd_valid_o <= 1'b1;
                    end else begin
                        delay_cnt <= delay_cnt - 20'd1;
                    end
                end
                eth_mgmt_pkg::SEQ_ISSUE: begin
                    // valid stays up, next step follows each accept
                    if (accept) begin
                        if (step == 4'd11) begin
                            state       <= eth_mgmt_pkg::SEQ_WAIT;
                            cmd_valid_o <= 1'b0;
                        end else begin
                            step <= step + 4'd1;
                        end
                    end
                end
                eth_mgmt_pkg::SEQ_WAIT: begin
                    // ready again means the last frame has gone out
                    if (cmd_ready_i) begin
                        state <= eth_mgmt_pkg::SEQ_DONE;
                    end
                end
                default: begin
                    cmd_valid_o <= 1'b0;
                end
            endcase
        end
    end

    a_no_valid_idle: assert property (@(posedge clk_125mhz_int) disable iff (rst_i)
        (state == eth_mgmt_pkg::SEQ_DELAY || state == eth_mgmt_pkg::SEQ_DONE)
        |-> !cmd_valid_o)
        else $error("command valid outside the issue phase");

    // held command must not change before the engine takes it
    a_hold_payload: assert property (@(posedge clk_125mhz_int) disable iff (rst_i)
        cmd_valid_o && !cmd_ready_i
        |=> cmd_valid_o && $stable(cmd_reg_o) && $stable(cmd_data_o))
        else $error("command changed while waiting for ready");

endmodule

//--- mdio_master.sv
//--------------------
// clause-22 MDIO write engine
// accepts one command on valid/ready and shifts a 64-bit frame
// out on mdc/mdio; mdio_t_o high releases the pin
//--------------------
`timescale 1ns/1ps
`include "eth_mgmt_macros.svh"

module mdio_master #(
    parameter logic [7:0] PRESCALE = `ETH_MGMT_MDC_PRESCALE
) (
    input  logic                     clk_125mhz_int,
    input  logic                     rst_i,
    input  eth_mgmt_pkg::phy_reg_t   cmd_reg_i,
    input  eth_mgmt_pkg::mdio_data_t cmd_data_i,
    input  logic                     cmd_valid_i,
    output logic                     cmd_ready_o,
    output logic                     mdc_o,
    output logic                     mdio_o,
    output logic                     mdio_t_o
);

    eth_mgmt_pkg::mdio_state_e state;
    logic [63:0] frame;
    logic [63:0] shift_reg;
    logic [7:0]  presc_cnt;
    logic [5:0]  bit_cnt;
    logic        accept;
    logic        fall_tick;

    // preamble, start, opcode, phy, reg, turnaround, data
    assign frame = {32'hFFFF_FFFF,
                    2'b01,
                    eth_mgmt_pkg::MDIO_OP_WRITE,
                    `ETH_MGMT_PHY_ADDR,
                    cmd_reg_i,
                    2'b10,
                    cmd_data_i};

    assign cmd_ready_o = (state == eth_mgmt_pkg::MDIO_IDLE);
    assign accept      = cmd_valid_i && cmd_ready_o;
    // end of the high half of mdc
    assign fall_tick   = (state == eth_mgmt_pkg::MDIO_SHIFT) && (presc_cnt == 8'd0) && mdc_o;

    always_ff @(posedge clk_125mhz_int or posedge rst_i) begin
        if (rst_i) begin
            state     <= eth_mgmt_pkg::MDIO_IDLE;
            presc_cnt <= 8'd0;
            bit_cnt   <= 6'd0;
            mdc_o     <= 1'b0;
            mdio_o    <= 1'b1;
            mdio_t_o  <= 1'b1;
        end else begin
            case (state)
                eth_mgmt_pkg::MDIO_IDLE: begin
                    if (cmd_valid_i) begin
                        state     <= eth_mgmt_pkg::MDIO_SHIFT;
                        presc_cnt <= PRESCALE;
                        bit_cnt   <= 6'd0;
                        mdc_o     <= 1'b0;
                        mdio_o    <= frame[63];
                        mdio_t_o  <= 1'b0;
                    end
                end
                eth_mgmt_pkg::MDIO_SHIFT: begin
                    if (presc_cnt != 8'd0) begin
                        presc_cnt <= presc_cnt - 8'd1;
                    end else begin
                        presc_cnt <= PRESCALE;
                        mdc_o     <= ~mdc_o;
                        // data moves only while mdc goes low
                        if (mdc_o) begin
                            if (bit_cnt == 6'd63) begin
                                state    <= eth_mgmt_pkg::MDIO_IDLE;
                                mdio_o   <= 1'b1;
                                mdio_t_o <= 1'b1;
                            end else begin
                                bit_cnt <= bit_cnt + 6'd1;
                                mdio_o  <= shift_reg[62];
                            end
                        end
                    end
                end
            endcase
        end
    end

    // frame bits, msb first
    always_ff @(posedge clk_125mhz_int) begin
        if (accept) begin
            shift_reg <= frame;
        end else if (fall_tick) begin
            shift_reg <= {shift_reg[62:0], 1'b0};
        end
    end

    // idle engine leaves the bus released
    a_idle_released: assert property (@(posedge clk_125mhz_int) disable iff (rst_i)
        state == eth_mgmt_pkg::MDIO_IDLE |-> mdio_t_o)
        else $error("MDIO idle with pin driven");

    // an accepted command drives the pin and blocks the next one
    a_accept_busy: assert property (@(posedge clk_125mhz_int) disable iff (rst_i)
        accept |=> !mdio_t_o && !cmd_ready_o && !mdc_o)
        else $error("MDIO frame did not start after accept");

endmodule

//--- reset_sync.sv
//--------------------
// reset synchronizer for the 125 MHz domain
// asserts with gt_tx_reset at once, releases STAGES edges later
//--------------------
`timescale 1ns/1ps
`include "eth_mgmt_macros.svh"

module reset_sync #(
    parameter int STAGES = `ETH_MGMT_SYNC_STAGES
) (
    input  logic clk_125mhz_int,
    input  logic gt_tx_reset,
    output logic rst_o
);

    logic [STAGES-1:0] sync_ff;

    // preset chain, zeros walk in after release
    always_ff @(posedge clk_125mhz_int or posedge gt_tx_reset) begin
        if (gt_tx_reset) begin
            sync_ff <= '1;
        end else begin
            sync_ff <= sync_ff << 1;
        end
    end

    assign rst_o = sync_ff[STAGES-1];

    // local reset must never lag the board reset
    a_rst_follows: assert property (@(posedge clk_125mhz_int) gt_tx_reset |-> rst_o)
        else $error("local reset low while gt_tx_reset is high");

endmodule

//--- eth_mgmt_pkg.sv
//--------------------
// shared types for the board management logic
// MDIO opcodes, engine and sequencer states, register and data words
// referenced by scoped name from the RTL modules
//--------------------
package eth_mgmt_pkg;

    // clause-22 opcodes
    typedef enum logic [1:0] {
        MDIO_OP_WRITE = 2'b01,
        MDIO_OP_READ  = 2'b10
    } mdio_op_e;

    // MDIO engine states
    typedef enum logic {
        MDIO_IDLE  = 1'b0,
        MDIO_SHIFT = 1'b1
    } mdio_state_e;

    // PHY init sequencer states
    typedef enum logic [1:0] {
        SEQ_DELAY = 2'd0,
        SEQ_ISSUE = 2'd1,
        SEQ_WAIT  = 2'd2,
        SEQ_DONE  = 2'd3
    } seq_state_e;

    // register number or PHY address
    typedef logic [4:0] phy_reg_t;

    // MDIO data word
    typedef logic [15:0] mdio_data_t;

endpackage

//--- eth_mgmt_macros.svh
//--------------------
// board management constants for the SGMII PHY bring-up
// PHY address, clause-22 register numbers, REGCR control words,
// startup delay, mdc prescale, reset sync depth and lane count
// include this file wherever one of the constants is needed
//--------------------
`ifndef ETH_MGMT_MACROS_SVH
`define ETH_MGMT_MACROS_SVH

// PHY strap address on the MDIO bus
`define ETH_MGMT_PHY_ADDR      5'd3

// indirect extended register access pair
`define ETH_MGMT_REG_REGCR     5'h0D
`define ETH_MGMT_REG_ADDAR     5'h0E

// REGCR words, devad 0x1F in address or data mode
`define ETH_MGMT_REGCR_ADDR    16'h001F
`define ETH_MGMT_REGCR_DATA    16'h401F

// startup delay in clock cycles
`define ETH_MGMT_INIT_DELAY    20'hFFFFF

// mdc half-period minus one, in clock cycles
`define ETH_MGMT_MDC_PRESCALE  8'd3

`define ETH_MGMT_SYNC_STAGES   4
`define ETH_MGMT_LANES         8

`endif
